// ==== etx_link.f ====
src/etx_txn_pkg.sv
src/etx_cfg_pkg.sv
src/etx_fifo.sv
src/etx_arbiter.sv
src/etx_protocol.sv
src/etx_cfg_regs.sv
src/etx_link.sv
bench/etx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the link testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module etx_tb \
   -f etx_link.f -o etx_sim &&
./obj_dir/etx_sim | tee /dev/stderr | grep -q "^Test OK$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== bench/etx_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the transmit link. Pushes LFSR transactions,
// models the arbitration and checks every framed beat
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module etx_tb;

   import etx_txn_pkg::*;
   import etx_cfg_pkg::*;

   logic        tx_lclk_par;
   logic        arst_n;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   logic [2:0]  push_en;                           // {rq, wr, rr}
   emesh_txn_t  push_data [3];
   wire  [2:0]  full_flags;
   logic        tx_wr_wait;
   logic        tx_rd_wait;
   logic        tx_frame;
   logic [7:0]  tx_data;

   logic [15:0] lfsr = 16'd44;                     // Seed
   logic [7:0]  exp_q [3][$];                      // Expected bytes per channel
   int          len_q [3][$];                      // Expected packet lengths
   int          sent_cnt [3];
   int          rem;                               // Beats left in packet
   int          cur;
   int          errors;
   int          beats;
   int          packets;
   logic        beat_seen;
   logic        beat_extra;
   logic        beat_drop;
   logic [7:0]  beat_exp;
   logic [7:0]  beat_act;
   logic        model_busy;
   logic        gpio_on;                           // Pins belong to GPIO
   logic        gpio_chk;
   logic        zero_chk;
   logic        gap_chk;
   logic [8:0]  gpio_val;
   string       test_name;

   etx_link UUT (.tx_lclk_par(tx_lclk_par), .arst_n(arst_n),
      .apb_req(apb_req), .apb_rsp(apb_rsp),
      .rr_wr_en(push_en[0]), .rr_wr_data(push_data[0]), .rr_full(full_flags[0]),
      .wr_wr_en(push_en[1]), .wr_wr_data(push_data[1]), .wr_full(full_flags[1]),
      .rq_wr_en(push_en[2]), .rq_wr_data(push_data[2]), .rq_full(full_flags[2]),
      .tx_wr_wait(tx_wr_wait), .tx_rd_wait(tx_rd_wait),
      .tx_frame(tx_frame), .tx_data(tx_data));

   initial
   begin
      tx_lclk_par = 1'b0;
      forever #50 tx_lclk_par = ~tx_lclk_par;     // 100 ns period
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16,14,13,11
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);                   // One step per bit
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic make_txn(input logic wr, input logic [1:0] dm, output emesh_txn_t t);
      logic [31:0] r;
      t.write    = wr;
      t.datamode = dm;
      rand_bits(4, r);
      t.ctrlmode = r[3:0];
      rand_bits(32, r);
      t.dstaddr  = r;
      rand_bits(32, r);
      t.data     = r;
      rand_bits(32, r);
      t.src.ret_addr = r;
   endtask

   // Expand by the byte-order rule, then drive one write strobe
   task automatic push(input int ch, input emesh_txn_t t, input logic counted);
      logic [31:0] src_word;
      logic        long_pkt;
      long_pkt = !t.write || t.datamode == DM_DOUBLE;
      src_word = t.write ? t.src.data_hi : t.src.ret_addr;
      if (counted)
      begin
         len_q[ch].push_back(long_pkt ? PKT_LEN_LONG : PKT_LEN_SHORT);
         exp_q[ch].push_back({t.ctrlmode, t.write, t.datamode, 1'b0});
         for (int i = 3; i >= 0; i--)
            exp_q[ch].push_back(t.dstaddr[8*i +: 8]);
         for (int i = 3; i >= 0; i--)
            exp_q[ch].push_back(t.data[8*i +: 8]);
         for (int i = 3; i >= 0; i--)
            if (long_pkt)
               exp_q[ch].push_back(src_word[8*i +: 8]);
      end
      @(posedge tx_lclk_par);
      push_en[ch]   <= 1'b1;
      push_data[ch] <= t;
      @(posedge tx_lclk_par);
      push_en[ch]   <= 1'b0;
   endtask

   // Highest priority queued channel that the far end lets through
   function automatic int pick_chan();
      if (len_q[0].size() != 0 && !tx_wr_wait)
         return 0;
      if (len_q[1].size() != 0 && !tx_wr_wait)
         return 1;
      if (len_q[2].size() != 0 && !tx_rd_wait)
         return 2;
      return -1;
   endfunction

   always @(posedge tx_lclk_par or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rem        = 0;
         beat_seen  <= 1'b0;
         beat_extra <= 1'b0;
         beat_drop  <= 1'b0;
         model_busy <= 1'b0;
         foreach (sent_cnt[i])
            sent_cnt[i] <= 0;
      end
      else
      begin
         beat_seen  <= 1'b0;
         beat_extra <= 1'b0;
         beat_drop  <= 1'b0;
         if (tx_frame && !gpio_on)
         begin
            if (rem == 0)
            begin
               cur = pick_chan();                  // New packet starts
               if (cur >= 0)
               begin
                  rem = len_q[cur].pop_front();
                  packets++;
                  sent_cnt[cur] <= sent_cnt[cur] + 1;
               end
               else
                  beat_extra <= 1'b1;
            end
            if (rem != 0)
            begin
               beat_exp  <= exp_q[cur].pop_front();
               beat_act  <= tx_data;
               beat_seen <= 1'b1;
               beats++;
               rem = rem - 1;
            end
         end
         else if (rem != 0)
         begin
            beat_drop <= 1'b1;                     // Drop rest of packet
            repeat (rem)
               void'(exp_q[cur].pop_front());
            rem = 0;
         end
         model_busy <= (rem != 0) ||
                       (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0);
      end
   end

   a_beat : assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      beat_seen |-> beat_act == beat_exp)
   else
   begin
      errors++;
      $display("** Error %s (beat): expected %h, actual %h", test_name, beat_exp, beat_act);
   end

   a_extra : assert property (@(posedge tx_lclk_par) disable iff (!arst_n) !beat_extra)
   else
   begin
      errors++;
      $display("%s: framed beat while no transaction was expected", test_name);
   end

   a_drop : assert property (@(posedge tx_lclk_par) disable iff (!arst_n) !beat_drop)
   else
   begin
      errors++;
      $display("%s: frame fell before the packet was complete", test_name);
   end

   a_no_gap : assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      gap_chk && model_busy |-> tx_frame)
   else
   begin
      errors++;
      $display("%s: idle gap between queued packets", test_name);
   end

   a_gpio : assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      gpio_chk |-> {tx_frame, tx_data} == gpio_val)
   else
   begin
      errors++;
      $display("** Error %s (pins): expected %h, actual %h", test_name, gpio_val,
               {tx_frame, tx_data});
   end

   a_zero : assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      zero_chk |-> {tx_frame, tx_data} == 9'd0)
   else
   begin
      errors++;
      $display("** Error %s (pins): expected 000, actual %h", test_name, {tx_frame, tx_data});
   end

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      a_value : assert (exp == act)
      else
      begin
         errors++;
         $display("** Error %s (%s): expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   // One APB transfer: setup phase, then a single access phase
   task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(posedge tx_lclk_par);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= wr;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(posedge tx_lclk_par);
      apb_req.penable <= 1'b1;
      @(posedge tx_lclk_par);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      check_val("pready", 1, apb_rsp.pready);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic reg_write(input logic [3:0] addr, input logic [31:0] wdata);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b1, addr, wdata, rd, err);
      check_val("write pslverr", 0, err);
   endtask

   task automatic reg_expect(input string what, input logic [3:0] addr, input logic [31:0] exp);
      logic [31:0] rd;
      logic        err;
      apb_xfer(1'b0, addr, 32'd0, rd, err);
      check_val(what, exp, rd);
      check_val("read pslverr", 0, err);
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge tx_lclk_par);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (model_busy && n < 2000)
      begin
         @(posedge tx_lclk_par);
         n++;
      end
      if (model_busy)
      begin
         errors++;
         $display("%s: timed out with transactions still unsent", test_name);
      end
   endtask

   task automatic wait_sent(input int ch, input int target);
      int n;
      n = 0;
      while (sent_cnt[ch] < target && n < 500)
      begin
         @(posedge tx_lclk_par);
         n++;
      end
      if (sent_cnt[ch] < target)
      begin
         errors++;
         $display("%s: timed out waiting for channel %0d packets", test_name, ch);
      end
   endtask

   task automatic wait_frame();
      int n;
      n = 0;
      while (!tx_frame && n < 100)
      begin
         @(posedge tx_lclk_par);
         n++;
      end
      if (!tx_frame)
      begin
         errors++;
         $display("%s: timed out waiting for the frame to rise", test_name);
      end
   endtask

   initial
   begin
      logic [31:0] rd;
      logic        err;
      emesh_txn_t  t;
      int          target;
      arst_n       = 1'b0;
      apb_req      = '0;
      push_en      = '0;
      push_data[0] = '0;
      push_data[1] = '0;
      push_data[2] = '0;
      tx_wr_wait   = 1'b0;
      tx_rd_wait   = 1'b0;
      gpio_on      = 1'b0;
      gpio_chk     = 1'b0;
      zero_chk     = 1'b0;
      gap_chk      = 1'b0;
      gpio_val     = '0;
      errors       = 0;
      beats        = 0;
      packets      = 0;
      test_name    = "reset";
      repeat (8) @(posedge tx_lclk_par);
      arst_n <= 1'b1;
      idle(2);

      test_name = "registers";
      reg_expect("status after reset", REG_STATUS, 32'h07);
      reg_write(REG_GPIO, 32'h0A5);                // Frame bit low
      reg_expect("gpio readback", REG_GPIO, 32'h0A5);
      reg_write(REG_CTRL, 32'h3);
      reg_expect("ctrl readback", REG_CTRL, 32'h3);
      reg_write(REG_CTRL, 32'h0);
      apb_xfer(1'b0, 4'd12, 32'd0, rd, err);
      check_val("offset 12 pslverr", 1, err);
      apb_xfer(1'b1, REG_STATUS, 32'd0, rd, err);
      check_val("status write pslverr", 1, err);

      test_name = "packet format";
      reg_write(REG_CTRL, 32'h1);
      make_txn(1'b0, 2'b10, t);                    // Read, sends ret_addr
      push(2, t, 1'b1);
      wait_drain();
      make_txn(1'b1, 2'b10, t);                    // Single write
      push(1, t, 1'b1);
      wait_drain();
      make_txn(1'b1, DM_DOUBLE, t);                // Sends data_hi
      push(1, t, 1'b1);
      wait_drain();

      test_name = "priority";
      reg_write(REG_CTRL, 32'h0);
      make_txn(1'b0, 2'b10, t);
      push(2, t, 1'b1);
      make_txn(1'b1, DM_DOUBLE, t);
      push(1, t, 1'b1);
      make_txn(1'b1, 2'b10, t);
      push(0, t, 1'b1);
      reg_write(REG_CTRL, 32'h1);
      wait_frame();
      gap_chk <= 1'b1;                             // Back to back from here
      wait_drain();
      gap_chk <= 1'b0;

      test_name = "push-back";
      reg_write(REG_CTRL, 32'h0);
      tx_wr_wait <= 1'b1;
      make_txn(1'b1, 2'b10, t);
      push(0, t, 1'b1);
      make_txn(1'b1, 2'b10, t);
      push(1, t, 1'b1);
      make_txn(1'b0, 2'b01, t);
      push(2, t, 1'b1);
      target = sent_cnt[2] + 1;
      reg_write(REG_CTRL, 32'h1);
      wait_sent(2, target);
      idle(4);
      reg_expect("status while held", REG_STATUS, 32'h44); // rr, wr queued; rq on pins
      tx_wr_wait <= 1'b0;
      wait_drain();

      test_name = "fifo full";
      reg_write(REG_CTRL, 32'h0);
      check_val("full before", 0, full_flags);
      for (int i = 0; i < FIFO_DEPTH + 2; i++)
      begin
         make_txn(1'b0, 2'b10, t);
         push(2, t, i < FIFO_DEPTH);               // Last two are dropped
      end
      check_val("full after pushes", 3'b100, full_flags); // Only rq is full
      reg_expect("status when full", REG_STATUS, 32'h23);
      reg_write(REG_CTRL, 32'h1);
      wait_drain();
      check_val("full after drain", 0, full_flags);

      test_name = "gpio";
      reg_write(REG_CTRL, 32'h0);
      make_txn(1'b1, 2'b10, t);
      push(1, t, 1'b1);
      gpio_val <= 9'h15A;
      gpio_on  <= 1'b1;
      reg_write(REG_GPIO, 32'h15A);
      reg_write(REG_CTRL, 32'h3);                  // Enabled, but pins on GPIO
      idle(2);
      gpio_chk <= 1'b1;
      idle(10);
      gpio_chk <= 1'b0;
      reg_expect("status holds write", REG_STATUS, 32'h05);
      reg_write(REG_CTRL, 32'h0);
      idle(3);
      gpio_on  <= 1'b0;
      zero_chk <= 1'b1;
      idle(10);
      zero_chk <= 0;
      reg_write(REG_CTRL, 32'h1);                  // Queued write now leaves
      wait_drain();

      test_name = "end";
      idle(5);
      $display("Checked %0d beats in %0d packets, %0d errors", beats, packets, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/etx_link.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transmit link top. Three channel FIFOs feed the arbiter,
// the packet engine drives the pins, APB sets it all up
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module etx_link
(
   input  wire                          tx_lclk_par,
   input  wire                          arst_n,
   input  wire etx_cfg_pkg::apb_req_t   apb_req,
   output etx_cfg_pkg::apb_rsp_t        apb_rsp,
   input  wire                          rr_wr_en,     // Read responses
   input  wire etx_txn_pkg::emesh_txn_t rr_wr_data,
   output logic                         rr_full,
   input  wire                          wr_wr_en,     // Writes
   input  wire etx_txn_pkg::emesh_txn_t wr_wr_data,
   output logic                         wr_full,
   input  wire                          rq_wr_en,     // Read requests
   input  wire etx_txn_pkg::emesh_txn_t rq_wr_data,
   output logic                         rq_full,
   input  wire                          tx_wr_wait,   // Far end push-back
   input  wire                          tx_rd_wait,
   output logic                         tx_frame,
   output logic [7:0]                   tx_data
);

   import etx_txn_pkg::*;
   import etx_cfg_pkg::*;

   wire emesh_txn_t rr_head;
   wire emesh_txn_t wr_head;
   wire emesh_txn_t rq_head;
   wire             rr_empty;
   wire             wr_empty;
   wire             rq_empty;
   wire             rr_rd_en;
   wire             wr_rd_en;
   wire             rq_rd_en;
   wire             txn_valid;
   wire emesh_txn_t txn;
   wire             ready;
   wire etx_cfg_t   cfg;

   etx_fifo #(.DEPTH(FIFO_DEPTH)) rr_fifo (.tx_lclk_par(tx_lclk_par), .arst_n(arst_n),
      .wr_en(rr_wr_en), .wr_data(rr_wr_data), .full(rr_full),
      .rd_en(rr_rd_en), .rd_data(rr_head), .empty(rr_empty));

   etx_fifo #(.DEPTH(FIFO_DEPTH)) wr_fifo (.tx_lclk_par(tx_lclk_par), .arst_n(arst_n),
      .wr_en(wr_wr_en), .wr_data(wr_wr_data), .full(wr_full),
      .rd_en(wr_rd_en), .rd_data(wr_head), .empty(wr_empty));

   etx_fifo #(.DEPTH(FIFO_DEPTH)) rq_fifo (.tx_lclk_par(tx_lclk_par), .arst_n(arst_n),
      .wr_en(rq_wr_en), .wr_data(rq_wr_data), .full(rq_full),
      .rd_en(rq_rd_en), .rd_data(rq_head), .empty(rq_empty));

   etx_arbiter etx_arbiter (.tx_lclk_par(tx_lclk_par), .arst_n(arst_n), .cfg(cfg),
      .rr_empty(rr_empty), .wr_empty(wr_empty), .rq_empty(rq_empty),
      .rr_data(rr_head), .wr_data(wr_head), .rq_data(rq_head),
      .rr_rd_en(rr_rd_en), .wr_rd_en(wr_rd_en), .rq_rd_en(rq_rd_en),
      .tx_wr_wait(tx_wr_wait), .tx_rd_wait(tx_rd_wait),
      .ready(ready), .txn_valid(txn_valid), .txn(txn));

   etx_protocol etx_protocol (.tx_lclk_par(tx_lclk_par), .arst_n(arst_n), .cfg(cfg),
      .txn_valid(txn_valid), .txn(txn), .ready(ready),
      .tx_frame(tx_frame), .tx_data(tx_data));

   etx_cfg_regs etx_cfg_regs (.tx_lclk_par(tx_lclk_par), .arst_n(arst_n),
      .apb_req(apb_req), .apb_rsp(apb_rsp),
      .fifo_empty({rq_empty, wr_empty, rr_empty}), // STATUS bits 2:0
      .fifo_full({rq_full, wr_full, rr_full}),     // STATUS bits 5:3
      .busy(~ready), .cfg(cfg));

endmodule

`default_nettype wire

// ==== src/etx_cfg_regs.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave with CTRL, GPIO and a live STATUS word.
// Zero wait states, errors on unknown offsets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module etx_cfg_regs
(
   input  wire                          tx_lclk_par,
   input  wire                          arst_n,
   input  wire etx_cfg_pkg::apb_req_t   apb_req,
   output etx_cfg_pkg::apb_rsp_t        apb_rsp,
   input  wire [2:0]                    fifo_empty,   // {rq, wr, rr}
   input  wire [2:0]                    fifo_full,    // {rq, wr, rr}
   input  wire                          busy,
   output etx_cfg_pkg::etx_cfg_t        cfg
);

   import etx_cfg_pkg::*;

   logic        access;
   logic        known;
   logic [31:0] rdata;

   assign access = apb_req.psel && apb_req.penable; // Access phase only

   always_comb
   begin
      known = 1'b1;
      rdata = '0;
      case (apb_req.paddr)
         REG_CTRL:   rdata = {30'd0, cfg.gpio_mode, cfg.enable};
         REG_GPIO:   rdata = {23'd0, cfg.gpio_value};
         REG_STATUS: rdata = {25'd0, busy, fifo_full, fifo_empty};
         default:    known = 1'b0;
      endcase
   end

   always_comb
   begin
      apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : 32'd0;
      apb_rsp.pready  = 1'b1;                      // Never stalls
      apb_rsp.pslverr = access &&
                        (!known || (apb_req.pwrite && apb_req.paddr == REG_STATUS));
   end

   always_ff @(posedge tx_lclk_par or negedge arst_n)
   begin
      if (!arst_n)
         cfg <= '0;                                // Link off, pins low
      else if (access && apb_req.pwrite)
      begin
         case (apb_req.paddr)
            REG_CTRL:
            begin
               cfg.enable    <= apb_req.pwdata[0];
               cfg.gpio_mode <= apb_req.pwdata[1];
            end
            REG_GPIO: cfg.gpio_value <= apb_req.pwdata[8:0];
            default:  cfg <= cfg;                  // STATUS and holes ignore writes
         endcase
      end
   end

   // Master must hold psel through the access phase
   a_penable_psel : assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

// ==== src/etx_protocol.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet engine. Turns one granted transaction into a
// framed byte stream, or shows the GPIO value while idle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module etx_protocol
(
   input  wire                          tx_lclk_par,
   input  wire                          arst_n,
   input  wire etx_cfg_pkg::etx_cfg_t   cfg,
   input  wire                          txn_valid,
   input  wire etx_txn_pkg::emesh_txn_t txn,
   output logic                         ready,
   output logic                         tx_frame,
   output logic [7:0]                   tx_data
);

   import etx_txn_pkg::*;

   emesh_txn_t lat;                                // Transaction in flight
   logic       busy;
   logic [3:0] cnt;                                // Index of beat on the pins
   logic [3:0] len;
   logic [3:0] nxt;
   logic       last;
   logic       take;

   // Whole packet as 13 bytes; short packets stop after 9
   function automatic logic [103:0] pkt_image(input emesh_txn_t t);
      // Src word is ret_addr for a read and data_hi for a double write
      return {t.ctrlmode, t.write, t.datamode, 1'b0, t.dstaddr, t.data, t.src};
   endfunction

   function automatic logic [7:0] pkt_byte(input logic [103:0] img, input logic [3:0] idx);
      return img[103 - 8 * idx -: 8];              // MSB first
   endfunction

   function automatic logic [3:0] pkt_len(input emesh_txn_t t);
      if (!t.write || t.datamode == DM_DOUBLE)
         return PKT_LEN_LONG;                      // Src word goes out too
      return PKT_LEN_SHORT;
   endfunction

   assign last  = busy && (cnt == len - 4'd1);
   assign ready = !busy || last;                   // Next packet follows with no gap
   assign take  = txn_valid && ready;
   assign nxt   = cnt + 4'd1;

   always_ff @(posedge tx_lclk_par or negedge arst_n)
   begin
      if (!arst_n)
      begin
         busy     <= 1'b0;
         cnt      <= '0;
         len      <= '0;
         tx_frame <= 1'b0;
         tx_data  <= '0;
      end
      else if (take)
      begin
         busy     <= 1'b1;
         cnt      <= '0;
         len      <= pkt_len(txn);
         tx_frame <= 1'b1;
         tx_data  <= pkt_byte(pkt_image(txn), 4'd0); // Header straight from input
      end
      else if (busy && !last)
      begin
         cnt     <= nxt;
         tx_data <= pkt_byte(pkt_image(lat), nxt);
      end
      else
      begin
         busy     <= 1'b0;                         // Idle pins
         tx_frame <= cfg.gpio_mode && cfg.gpio_value[8];
         tx_data  <= cfg.gpio_mode ? cfg.gpio_value[7:0] : 8'd0;
      end
   end

   always_ff @(posedge tx_lclk_par)
   begin
      if (take)
         lat <= txn;
   end

   // Arbiter offers only into a free engine
   a_valid_ready : assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      txn_valid |-> ready);

endmodule

`default_nettype wire

// ==== src/etx_arbiter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link control. Syncs the far-end wait pins, picks a
// channel by fixed priority and hands its head to the packet engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module etx_arbiter
(
   input  wire                          tx_lclk_par,
   input  wire                          arst_n,
   input  wire etx_cfg_pkg::etx_cfg_t   cfg,
   input  wire                          rr_empty,
   input  wire                          wr_empty,
   input  wire                          rq_empty,
   input  wire etx_txn_pkg::emesh_txn_t rr_data,
   input  wire etx_txn_pkg::emesh_txn_t wr_data,
   input  wire etx_txn_pkg::emesh_txn_t rq_data,
   output logic                         rr_rd_en,
   output logic                         wr_rd_en,
   output logic                         rq_rd_en,
   input  wire                          tx_wr_wait,
   input  wire                          tx_rd_wait,
   input  wire                          ready,
   output logic                         txn_valid,
   output etx_txn_pkg::emesh_txn_t      txn
);

   import etx_txn_pkg::*;

   logic [1:0] wr_wait_sync;                       // Pin crosses from far end
   logic [1:0] rd_wait_sync;
   logic       rr_ok;
   logic       wr_ok;
   logic       rq_ok;
   logic       grant;
   chan_e      pick;

   always_ff @(posedge tx_lclk_par or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_wait_sync <= '0;
         rd_wait_sync <= '0;
      end
      else
      begin
         wr_wait_sync <= {wr_wait_sync[0], tx_wr_wait};
         rd_wait_sync <= {rd_wait_sync[0], tx_rd_wait};
      end
   end

   assign rr_ok = !rr_empty && !wr_wait_sync[1];   // Responses count as writes
   assign wr_ok = !wr_empty && !wr_wait_sync[1];
   assign rq_ok = !rq_empty && !rd_wait_sync[1];

   always_comb
   begin
      if (rr_ok)
         pick = CH_RR;                             // Highest priority
      else if (wr_ok)
         pick = CH_WR;
      else
         pick = CH_RQ;
   end

   // Only grant into a free engine, so valid never has to wait
   assign grant = cfg.enable && !cfg.gpio_mode && ready && (rr_ok || wr_ok || rq_ok);

   assign rr_rd_en  = grant && (pick == CH_RR);    // Pop on the transfer edge
   assign wr_rd_en  = grant && (pick == CH_WR);
   assign rq_rd_en  = grant && (pick == CH_RQ);
   assign txn_valid = grant;

   always_comb
   begin
      case (pick)
         CH_RR:   txn = rr_data;
         CH_WR:   txn = wr_data;
         default: txn = rq_data;
      endcase
   end

   // Engine is busy right after a grant, so no pop follows a pop
   a_one_pop : assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      (rr_rd_en || wr_rd_en || rq_rd_en) |=> !(rr_rd_en || wr_rd_en || rq_rd_en));

endmodule

`default_nettype wire

// ==== src/etx_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous first-word-fall-through FIFO for one
// transaction channel. DEPTH must be a power of two (2 or more)
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module etx_fifo
#(
   parameter int DEPTH = etx_txn_pkg::FIFO_DEPTH
)
(
   input  wire                         tx_lclk_par,
   input  wire                         arst_n,
   input  wire                         wr_en,
   input  wire etx_txn_pkg::emesh_txn_t wr_data,
   output logic                        full,
   input  wire                         rd_en,
   output etx_txn_pkg::emesh_txn_t     rd_data,
   output logic                        empty
);

   import etx_txn_pkg::*;

   localparam int AW = $clog2(DEPTH);              // Address bits

   emesh_txn_t mem [DEPTH];                        // Storage
   logic [AW:0] wr_ptr;                            // Extra MSB tells wrap
   logic [AW:0] rd_ptr;
   logic        push;
   logic        pop;

   assign push = wr_en && !full;                   // Writes while full are lost
   assign pop  = rd_en && !empty;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]); // Same slot, one lap apart

   assign rd_data = mem[rd_ptr[AW-1:0]];           // Head visible before pop

   always_ff @(posedge tx_lclk_par or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge tx_lclk_par)
   begin
      if (push)
         mem[wr_ptr[AW-1:0]] <= wr_data;
   end

   // Arbiter only pops a channel that holds data
   a_no_pop_empty : assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      !(rd_en && empty));

endmodule

`default_nettype wire

// ==== src/etx_cfg_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB bus types, register map and the config word
// that the register block hands to the datapath
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package etx_cfg_pkg;

   localparam logic [3:0] REG_CTRL   = 4'd0;       // Bit 0 enable, bit 1 gpio_mode
   localparam logic [3:0] REG_GPIO   = 4'd4;       // Bit 8 frame, bits 7:0 data
   localparam logic [3:0] REG_STATUS = 4'd8;       // Read only

   typedef struct packed
   {
      logic        psel;
      logic        penable;                        // Access phase
      logic        pwrite;
      logic [3:0]  paddr;                          // Byte offset
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed
   {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   typedef struct packed
   {
      logic        enable;                         // Allows grants
      logic        gpio_mode;                      // Drive pins from gpio_value
      logic [8:0]  gpio_value;                     // {frame, data}
   } etx_cfg_t;

endpackage

`default_nettype wire

// ==== src/etx_txn_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mesh transaction format shared by the channel FIFOs,
// the arbiter and the packet engine, plus packet lengths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package etx_txn_pkg;

   localparam int FIFO_DEPTH = 4;                  // Entries per channel FIFO

   localparam logic [1:0] DM_DOUBLE = 2'b11;       // 64-bit write

   localparam logic [3:0] PKT_LEN_LONG  = 4'd13;   // Header + dst + data + src
   localparam logic [3:0] PKT_LEN_SHORT = 4'd9;    // Header + dst + data

   // The src word means different things to reads and double writes
   typedef union packed
   {
      logic [31:0] ret_addr;                       // Return address of a read
      logic [31:0] data_hi;                        // Upper word of a 64-bit write
   } src_field_u;

   typedef struct packed
   {
      logic        write;                          // Low for read request/response
      logic [1:0]  datamode;                       // Access size
      logic [3:0]  ctrlmode;                       // Passed through in header
      logic [31:0] dstaddr;
      logic [31:0] data;
      src_field_u  src;
   } emesh_txn_t;

   // Channel ids in priority order
   typedef enum logic [1:0]
   {
      CH_RR = 2'd0,                                // Read response
      CH_WR = 2'd1,                                // Write
      CH_RQ = 2'd2                                 // Read request
   } chan_e;

endpackage

`default_nettype wire
